// ==== hw/oflow_feature_pkg.sv ====
`default_nettype none

package oflow_feature_pkg;

	// --------------------------------------------------
	// box and appearance fields
	// --------------------------------------------------
	localparam int COORD_LEN     = 8;               // one corner coordinate
	localparam int POSITION_LEN  = 4 * COORD_LEN;   // {tl_x, tl_y, br_x, br_y}
	localparam int WIDTH_LEN     = 8;
	localparam int HEIGHT_LEN    = 8;
	localparam int COLOR_LEN     = 24;              // packed rgb
	localparam int D_HISTORY_LEN = 3;               // frames seen, small count

	// position sub-fields, tl_x at the top
	localparam int BR_Y_LSB = 0;
	localparam int BR_X_LSB = BR_Y_LSB + COORD_LEN;
	localparam int TL_Y_LSB = BR_X_LSB + COORD_LEN;
	localparam int TL_X_LSB = TL_Y_LSB + COORD_LEN;

	// --------------------------------------------------
	// packed table entry
	// --------------------------------------------------
	// msb first: position, width, height, color1, color2, history
	localparam int HISTORY_LSB  = 0;
	localparam int COLOR2_LSB   = HISTORY_LSB + D_HISTORY_LEN;
	localparam int COLOR1_LSB   = COLOR2_LSB + COLOR_LEN;
	localparam int HEIGHT_LSB   = COLOR1_LSB + COLOR_LEN;
	localparam int WIDTH_LSB    = HEIGHT_LSB + HEIGHT_LEN;
	localparam int POSITION_LSB = WIDTH_LSB + WIDTH_LEN;
	localparam int FEATURE_LEN  = POSITION_LSB + POSITION_LEN;  // 99

	// table geometry
	localparam int N_OBJ  = 4;
	localparam int ID_LEN = 2;   // index into the table

endpackage

`default_nettype wire

// ==== hw/oflow_score_pkg.sv ====
`default_nettype none

package oflow_score_pkg;

	// --------------------------------------------------
	// scoring widths
	// --------------------------------------------------
	localparam int WEIGHT_LEN           = 4;
	localparam int FRAC_LEN             = 10;            // q.10 fixed point
	localparam int IOU_LEN              = FRAC_LEN + 1;  // q0.10, 1024 is one
	localparam int AREA_LEN             = 17;            // holds sum of two 16b areas
	localparam int D_HISTORY_METRIC_LEN = 8;             // 1 << history, up to 128
	localparam int SUM_LEN              = 42;            // weighted sum, q.10
	localparam int SCORE_LEN            = SUM_LEN - FRAC_LEN;

	// --------------------------------------------------
	// FSM states
	// --------------------------------------------------
	typedef enum logic [1:0] {
		iou_idle,
		iou_area,     // union from registered areas
		iou_divide    // one quotient bit per cycle
	} iou_state_t;

	typedef enum logic [1:0] {
		met_idle,
		met_calc,     // waits on iou, then distances
		met_mult,
		met_sum
	} metric_state_t;

	typedef enum logic [1:0] {
		sel_idle,
		sel_scan,
		sel_wait,
		sel_done
	} select_state_t;

endpackage

`default_nettype wire

// ==== hw/oflow_prev_table.sv ====
`default_nettype none

module oflow_prev_table
	import oflow_feature_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   wr,
	input  logic [ID_LEN-1:0]      wr_addr,
	input  logic [FEATURE_LEN-1:0] wr_features,
	input  logic                   clear,
	input  logic [ID_LEN-1:0]      rd_addr,
	output logic [FEATURE_LEN-1:0] rd_features,
	output logic [N_OBJ-1:0]       entry_valid
);

	// feature words of earlier frames
	logic [FEATURE_LEN-1:0] entries [N_OBJ];

	always_ff @(posedge clk) begin
		if (wr)
			entries[wr_addr] <= wr_features;
	end

	// valid bits, a write beats a clear on its own entry
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			entry_valid <= '0;
		end else begin
			for (int i = 0; i < N_OBJ; i++) begin
				if (wr && (wr_addr == ID_LEN'(i)))
					entry_valid[i] <= 1'b1;
				else if (clear)
					entry_valid[i] <= 1'b0;
			end
		end
	end

	// combinational read, same cycle as rd_addr
	assign rd_features = entries[rd_addr];

endmodule

`default_nettype wire

// ==== hw/oflow_calc_iou.sv ====
`default_nettype none

module oflow_calc_iou
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    start,
	input  logic [POSITION_LEN-1:0] pos_cur,
	input  logic [POSITION_LEN-1:0] pos_prev,
	input  logic [WIDTH_LEN-1:0]    w_cur,
	input  logic [HEIGHT_LEN-1:0]   h_cur,
	input  logic [WIDTH_LEN-1:0]    w_prev,
	input  logic [HEIGHT_LEN-1:0]   h_prev,
	output logic                    valid_iou,
	output logic [IOU_LEN-1:0]      iou
);

	iou_state_t                  state;
	logic [$clog2(FRAC_LEN)-1:0] cnt;      // divide step

	logic [COORD_LEN-1:0] x_ov;
	logic [COORD_LEN-1:0] y_ov;
	logic [AREA_LEN-1:0]  inter_r;
	logic [AREA_LEN-1:0]  area_cur_r;
	logic [AREA_LEN-1:0]  area_prev_r;
	logic [AREA_LEN-1:0]  union_c;
	logic [AREA_LEN-1:0]  union_r;      // divisor
	logic                 int_bit;      // boxes equal, iou of one

	logic [AREA_LEN-1:0]  rem;          // partial remainder, always below union
	logic [AREA_LEN:0]    rem_sh;
	logic [AREA_LEN:0]    rem_sub;
	logic                 q_bit;
	logic [IOU_LEN-1:0]   q;
	logic [IOU_LEN-1:0]   q_next;

	// clamped overlap of two intervals on one axis
	function automatic logic [COORD_LEN-1:0] overlap(
		input logic [COORD_LEN-1:0] a_lo,
		input logic [COORD_LEN-1:0] a_hi,
		input logic [COORD_LEN-1:0] b_lo,
		input logic [COORD_LEN-1:0] b_hi
	);
		logic [COORD_LEN-1:0] lo;
		logic [COORD_LEN-1:0] hi;
		lo = (a_lo > b_lo) ? a_lo : b_lo;   // larger left edge
		hi = (a_hi < b_hi) ? a_hi : b_hi;   // smaller right edge
		return (hi > lo) ? hi - lo : '0;
	endfunction

	assign x_ov = overlap(pos_cur[TL_X_LSB +: COORD_LEN], pos_cur[BR_X_LSB +: COORD_LEN],
	                      pos_prev[TL_X_LSB +: COORD_LEN], pos_prev[BR_X_LSB +: COORD_LEN]);
	assign y_ov = overlap(pos_cur[TL_Y_LSB +: COORD_LEN], pos_cur[BR_Y_LSB +: COORD_LEN],
	                      pos_prev[TL_Y_LSB +: COORD_LEN], pos_prev[BR_Y_LSB +: COORD_LEN]);

	// --------------------------------------------------
	// restoring divider, inter * 1024 / union
	// --------------------------------------------------
	assign union_c = area_cur_r + area_prev_r - inter_r;
	assign int_bit = (union_c != '0) && (inter_r == union_c);
	assign rem_sh  = {rem, 1'b0};
	assign rem_sub = rem_sh - {1'b0, union_r};
	assign q_bit   = (union_r != '0) && (rem_sh >= {1'b0, union_r});   // zero union gives 0
	assign q_next  = {q[IOU_LEN-2:0], q_bit};

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state     <= iou_idle;
			cnt       <= '0;
			valid_iou <= 1'b0;
		end else begin
			valid_iou <= 1'b0;
			case (state)
				iou_idle:
					if (start) state <= iou_area;
				iou_area: begin
					cnt   <= '0;
					state <= iou_divide;
				end
				iou_divide: begin
					cnt <= cnt + 1'b1;
					if (cnt == FRAC_LEN - 1) begin   // last fraction bit
						valid_iou <= 1'b1;
						state     <= iou_idle;
					end
				end
				default:
					state <= iou_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			iou_idle: begin
				if (start) begin
					inter_r     <= x_ov * y_ov;
					area_cur_r  <= w_cur * h_cur;
					area_prev_r <= w_prev * h_prev;
				end
			end
			iou_area: begin
				union_r <= union_c;
				rem     <= int_bit ? '0 : inter_r;
				q       <= IOU_LEN'(int_bit);   // integer bit, shifted up by the divide
			end
			iou_divide: begin
				rem <= q_bit ? rem_sub[AREA_LEN-1:0] : rem_sh[AREA_LEN-1:0];
				q   <= q_next;
				if (cnt == FRAC_LEN - 1)
					iou <= q_next;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/oflow_similarity_metric.sv ====
`default_nettype none

module oflow_similarity_metric
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_N,
	input  logic                    start,
	input  logic [POSITION_LEN-1:0] position_cur,
	input  logic [WIDTH_LEN-1:0]    width_cur,
	input  logic [HEIGHT_LEN-1:0]   height_cur,
	input  logic [COLOR_LEN-1:0]    color1_cur,
	input  logic [COLOR_LEN-1:0]    color2_cur,
	input  logic [FEATURE_LEN-1:0]  features_of_prev,
	input  logic [WEIGHT_LEN-1:0]   iou_weight,
	input  logic [WEIGHT_LEN-1:0]   w_weight,
	input  logic [WEIGHT_LEN-1:0]   h_weight,
	input  logic [WEIGHT_LEN-1:0]   color1_weight,
	input  logic [WEIGHT_LEN-1:0]   color2_weight,
	input  logic [WEIGHT_LEN-1:0]   dhistory_weight,
	output logic                    valid,
	output logic [SCORE_LEN-1:0]    score
);

	// previous entry, unpacked
	logic [POSITION_LEN-1:0]  position_prev;
	logic [WIDTH_LEN-1:0]     width_prev;
	logic [HEIGHT_LEN-1:0]    height_prev;
	logic [COLOR_LEN-1:0]     color1_prev;
	logic [COLOR_LEN-1:0]     color2_prev;
	logic [D_HISTORY_LEN-1:0] d_history_prev;

	logic               start_iou;
	logic               valid_iou;
	logic [IOU_LEN-1:0] iou;

	// distance metrics, integer except iou
	logic [IOU_LEN-1:0]              iou_metric;   // 1 - iou, q0.10
	logic [WIDTH_LEN-1:0]            w_metric;
	logic [HEIGHT_LEN-1:0]           h_metric;
	logic [COLOR_LEN-1:0]            color1_metric;
	logic [COLOR_LEN-1:0]            color2_metric;
	logic [D_HISTORY_METRIC_LEN-1:0] d_history_metric;

	// weighted terms, all q.10
	logic [SUM_LEN-1:0] iou_term;
	logic [SUM_LEN-1:0] w_term;
	logic [SUM_LEN-1:0] h_term;
	logic [SUM_LEN-1:0] color1_term;
	logic [SUM_LEN-1:0] color2_term;
	logic [SUM_LEN-1:0] d_history_term;
	logic [SUM_LEN-1:0] sum_all;

	metric_state_t state;
	metric_state_t next_state;

	function automatic logic [COLOR_LEN-1:0] l1_dist(
		input logic [COLOR_LEN-1:0] a,
		input logic [COLOR_LEN-1:0] b
	);
		return (a > b) ? a - b : b - a;
	endfunction

	assign position_prev  = features_of_prev[POSITION_LSB +: POSITION_LEN];
	assign width_prev     = features_of_prev[WIDTH_LSB +: WIDTH_LEN];
	assign height_prev    = features_of_prev[HEIGHT_LSB +: HEIGHT_LEN];
	assign color1_prev    = features_of_prev[COLOR1_LSB +: COLOR_LEN];
	assign color2_prev    = features_of_prev[COLOR2_LSB +: COLOR_LEN];
	assign d_history_prev = features_of_prev[HISTORY_LSB +: D_HISTORY_LEN];

	oflow_calc_iou u_calc_iou (
		.clk       (clk),
		.reset_N   (reset_N),
		.start     (start_iou),
		.pos_cur   (position_cur),
		.pos_prev  (position_prev),
		.w_cur     (width_cur),
		.h_cur     (height_cur),
		.w_prev    (width_prev),
		.h_prev    (height_prev),
		.valid_iou (valid_iou),
		.iou       (iou)
	);

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	assign start_iou = (state == met_idle) && start;   // iou runs from the start cycle

	always_comb begin
		next_state = state;
		case (state)
			met_idle: if (start) next_state = met_calc;
			met_calc: if (valid_iou) next_state = met_mult;
			met_mult: next_state = met_sum;
			met_sum:  next_state = met_idle;
			default:  next_state = met_idle;
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= met_idle;
			valid <= 1'b0;
		end else begin
			state <= next_state;
			valid <= (state == met_sum);   // score lands with it
		end
	end

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	assign sum_all = iou_term + w_term + h_term + color1_term + color2_term + d_history_term;

	always_ff @(posedge clk) begin
		if ((state == met_calc) && valid_iou) begin
			iou_metric       <= IOU_LEN'(1 << FRAC_LEN) - iou;
			w_metric         <= WIDTH_LEN'(l1_dist(COLOR_LEN'(width_prev), COLOR_LEN'(width_cur)));
			h_metric         <= HEIGHT_LEN'(l1_dist(COLOR_LEN'(height_prev),
			                                        COLOR_LEN'(height_cur)));
			color1_metric    <= l1_dist(color1_prev, color1_cur);
			color2_metric    <= l1_dist(color2_prev, color2_cur);
			d_history_metric <= D_HISTORY_METRIC_LEN'(1) << d_history_prev;   // older is costlier
		end
		if (state == met_mult) begin
			iou_term       <= SUM_LEN'(iou_weight) * SUM_LEN'(iou_metric);   // already q.10
			w_term         <= SUM_LEN'(w_weight) * (SUM_LEN'(w_metric) << FRAC_LEN);
			h_term         <= SUM_LEN'(h_weight) * (SUM_LEN'(h_metric) << FRAC_LEN);
			color1_term    <= SUM_LEN'(color1_weight) * (SUM_LEN'(color1_metric) << FRAC_LEN);
			color2_term    <= SUM_LEN'(color2_weight) * (SUM_LEN'(color2_metric) << FRAC_LEN);
			d_history_term <= SUM_LEN'(dhistory_weight)
			                  * (SUM_LEN'(d_history_metric) << FRAC_LEN);
		end
		if (state == met_sum)
			score <= sum_all[SUM_LEN-1:FRAC_LEN];   // drop fraction
	end

endmodule

`default_nettype wire

// ==== hw/oflow_match_select.sv ====
`default_nettype none

module oflow_match_select
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 track,
	input  logic [N_OBJ-1:0]     entry_valid,
	input  logic                 metric_valid,
	input  logic [SCORE_LEN-1:0] metric_score,
	output logic                 busy,
	output logic                 done,
	output logic                 found,
	output logic [ID_LEN-1:0]    best_id,
	output logic [SCORE_LEN-1:0] best_score,
	output logic [ID_LEN-1:0]    rd_addr,
	output logic                 metric_start
);

	select_state_t state;

	// running best of the current search
	logic                 run_found;
	logic [ID_LEN-1:0]    run_id;
	logic [SCORE_LEN-1:0] run_score;

	logic                 last;       // index at the final entry
	logic                 take;       // new score beats the best so far
	logic                 finish;
	logic                 nxt_found;
	logic [ID_LEN-1:0]    nxt_id;
	logic [SCORE_LEN-1:0] nxt_score;

	assign last = (rd_addr == ID_LEN'(N_OBJ - 1));
	assign take = (state == sel_wait) && metric_valid
	              && (!run_found || (metric_score < run_score));   // strict, lower index wins tie

	assign nxt_found = run_found | take;
	assign nxt_id    = take ? rd_addr : run_id;
	assign nxt_score = take ? metric_score : run_score;

	assign finish = last && (((state == sel_scan) && !entry_valid[rd_addr])
	                         || ((state == sel_wait) && metric_valid));

	assign busy = (state == sel_scan) || (state == sel_wait);
	assign done = (state == sel_done);   // busy already low here

	// --------------------------------------------------
	// scan FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state        <= sel_idle;
			rd_addr      <= '0;
			metric_start <= 1'b0;
		end else begin
			metric_start <= 1'b0;
			case (state)
				sel_idle: begin
					if (track) begin
						rd_addr <= '0;
						state   <= sel_scan;
					end
				end
				sel_scan: begin
					if (entry_valid[rd_addr]) begin
						metric_start <= 1'b1;   // one cycle after the index
						state        <= sel_wait;
					end else if (last) begin
						state <= sel_done;
					end else begin
						rd_addr <= rd_addr + 1'b1;   // skip empty slot
					end
				end
				sel_wait: begin
					if (metric_valid) begin
						if (last) begin
							state <= sel_done;
						end else begin
							rd_addr <= rd_addr + 1'b1;
							state   <= sel_scan;
						end
					end
				end
				default:
					state <= sel_idle;
			endcase
		end
	end

	// best so far, published only at done
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			run_found  <= 1'b0;
			run_id     <= '0;
			run_score  <= '0;
			found      <= 1'b0;
			best_id    <= '0;
			best_score <= '0;
		end else begin
			if ((state == sel_idle) && track) begin
				run_found <= 1'b0;   // fresh search
			end else begin
				run_found <= nxt_found;
				run_id    <= nxt_id;
				run_score <= nxt_score;
			end
			if (finish) begin
				found      <= nxt_found;
				best_id    <= nxt_id;
				best_score <= nxt_score;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/oflow_tracker_top.sv ====
`default_nettype none

module oflow_tracker_top
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_N,
	// table load
	input  logic                    wr,
	input  logic [ID_LEN-1:0]       wr_addr,
	input  logic [FEATURE_LEN-1:0]  wr_features,
	input  logic                    clear,
	// current detection
	input  logic                    track,
	input  logic [POSITION_LEN-1:0] cur_position,
	input  logic [WIDTH_LEN-1:0]    cur_width,
	input  logic [HEIGHT_LEN-1:0]   cur_height,
	input  logic [COLOR_LEN-1:0]    cur_color1,
	input  logic [COLOR_LEN-1:0]    cur_color2,
	input  logic [WEIGHT_LEN-1:0]   iou_weight,
	input  logic [WEIGHT_LEN-1:0]   w_weight,
	input  logic [WEIGHT_LEN-1:0]   h_weight,
	input  logic [WEIGHT_LEN-1:0]   color1_weight,
	input  logic [WEIGHT_LEN-1:0]   color2_weight,
	input  logic [WEIGHT_LEN-1:0]   dhistory_weight,
	// match result
	output logic                    busy,
	output logic                    done,
	output logic                    found,
	output logic [ID_LEN-1:0]       best_id,
	output logic [SCORE_LEN-1:0]    best_score
);

	logic [ID_LEN-1:0]      rd_addr;
	logic [FEATURE_LEN-1:0] rd_features;
	logic [N_OBJ-1:0]       entry_valid;
	logic                   metric_start;
	logic                   metric_valid;
	logic [SCORE_LEN-1:0]   metric_score;

	oflow_prev_table u_prev_table (
		.clk         (clk),
		.reset_N     (reset_N),
		.wr          (wr),
		.wr_addr     (wr_addr),
		.wr_features (wr_features),
		.clear       (clear),
		.rd_addr     (rd_addr),
		.rd_features (rd_features),
		.entry_valid (entry_valid)
	);

	oflow_match_select u_match_select (
		.clk          (clk),
		.reset_N      (reset_N),
		.track        (track),
		.entry_valid  (entry_valid),
		.metric_valid (metric_valid),
		.metric_score (metric_score),
		.busy         (busy),
		.done         (done),
		.found        (found),
		.best_id      (best_id),
		.best_score   (best_score),
		.rd_addr      (rd_addr),
		.metric_start (metric_start)
	);

	// scores the entry at rd_addr against the detection
	oflow_similarity_metric u_similarity_metric (
		.clk              (clk),
		.reset_N          (reset_N),
		.start            (metric_start),
		.position_cur     (cur_position),
		.width_cur        (cur_width),
		.height_cur       (cur_height),
		.color1_cur       (cur_color1),
		.color2_cur       (cur_color2),
		.features_of_prev (rd_features),
		.iou_weight       (iou_weight),
		.w_weight         (w_weight),
		.h_weight         (h_weight),
		.color1_weight    (color1_weight),
		.color2_weight    (color2_weight),
		.dhistory_weight  (dhistory_weight),
		.valid            (metric_valid),
		.score            (metric_score)
	);

endmodule

`default_nettype wire

// ==== sim/oflow_tracker_model.svh ====
`ifndef OFLOW_TRACKER_MODEL_SVH
`define OFLOW_TRACKER_MODEL_SVH

// --------------------------------------------------
// stimulus table
// --------------------------------------------------
localparam int N_CASES       = 12;
localparam int MAX_WR        = 4;
localparam int METRIC_CYCLES = 15;   // start to valid, 12 iou then calc mult sum

int seed = 40;   // colours and weights

int                     n_wr      [N_CASES];
logic [ID_LEN-1:0]      wr_id     [N_CASES][MAX_WR];
logic [FEATURE_LEN-1:0] wr_feat   [N_CASES][MAX_WR];
bit                     do_clear  [N_CASES];      // clear after the writes
bit                     retrack   [N_CASES];      // second track while busy
logic [FEATURE_LEN-1:0] det       [N_CASES];      // detection, history field unused
logic [WEIGHT_LEN-1:0]  wgt       [N_CASES][6];   // iou w h color1 color2 history
bit                     exp_found [N_CASES];
logic [ID_LEN-1:0]      exp_id    [N_CASES];
logic [SCORE_LEN-1:0]   exp_score [N_CASES];
int                     exp_lat   [N_CASES];      // -1 unless exactly one entry valid

function automatic longint field(logic [FEATURE_LEN-1:0] f, int lsb, int len);
	return longint'((f >> lsb) & ((FEATURE_LEN'(1) << len) - 1'b1));
endfunction

function automatic longint absdiff(longint a, longint b);
	return (a > b) ? a - b : b - a;
endfunction

// box from corner and size, so w and h agree with the corners
function automatic logic [FEATURE_LEN-1:0] make_entry(int x, int y, int w, int h, int hist,
		logic [COLOR_LEN-1:0] c1, logic [COLOR_LEN-1:0] c2);
	return {COORD_LEN'(x), COORD_LEN'(y), COORD_LEN'(x + w), COORD_LEN'(y + h),
	        WIDTH_LEN'(w), HEIGHT_LEN'(h), c1, c2, D_HISTORY_LEN'(hist)};
endfunction

function automatic logic [FEATURE_LEN-1:0] with_hist(logic [FEATURE_LEN-1:0] f, int hist);
	f[HISTORY_LSB +: D_HISTORY_LEN] = D_HISTORY_LEN'(hist);
	return f;
endfunction

function automatic logic [COLOR_LEN-1:0] rnd_color();
	return COLOR_LEN'($random(seed));
endfunction

// --------------------------------------------------
// reference scoring
// --------------------------------------------------
function automatic longint axis_overlap(logic [FEATURE_LEN-1:0] a, logic [FEATURE_LEN-1:0] b,
		int lo_lsb, int hi_lsb);
	longint lo;
	longint hi;
	lo = field(a, POSITION_LSB + lo_lsb, COORD_LEN);
	if (field(b, POSITION_LSB + lo_lsb, COORD_LEN) > lo)
		lo = field(b, POSITION_LSB + lo_lsb, COORD_LEN);   // larger left edge
	hi = field(a, POSITION_LSB + hi_lsb, COORD_LEN);
	if (field(b, POSITION_LSB + hi_lsb, COORD_LEN) < hi)
		hi = field(b, POSITION_LSB + hi_lsb, COORD_LEN);   // smaller right edge
	return (hi > lo) ? hi - lo : 0;
endfunction

function automatic longint ref_iou(logic [FEATURE_LEN-1:0] a, logic [FEATURE_LEN-1:0] b);
	longint inter;
	longint uni;
	inter = axis_overlap(a, b, TL_X_LSB, BR_X_LSB) * axis_overlap(a, b, TL_Y_LSB, BR_Y_LSB);
	uni   = field(a, WIDTH_LSB, WIDTH_LEN) * field(a, HEIGHT_LSB, HEIGHT_LEN)
	        + field(b, WIDTH_LSB, WIDTH_LEN) * field(b, HEIGHT_LSB, HEIGHT_LEN) - inter;
	return (uni == 0) ? 0 : (inter << FRAC_LEN) / uni;   // q0.10, floor
endfunction

function automatic longint dist_term(int c, logic [FEATURE_LEN-1:0] e, int k, int lsb,
		int len);
	return (longint'(wgt[c][k]) * absdiff(field(det[c], lsb, len), field(e, lsb, len)))
	       << FRAC_LEN;
endfunction

function automatic longint ref_score(int c, logic [FEATURE_LEN-1:0] e);
	longint sum;
	sum = longint'(wgt[c][0]) * ((1 << FRAC_LEN) - ref_iou(det[c], e))
	      + dist_term(c, e, 1, WIDTH_LSB, WIDTH_LEN)
	      + dist_term(c, e, 2, HEIGHT_LSB, HEIGHT_LEN)
	      + dist_term(c, e, 3, COLOR1_LSB, COLOR_LEN)
	      + dist_term(c, e, 4, COLOR2_LSB, COLOR_LEN)
	      + ((longint'(wgt[c][5]) << field(e, HISTORY_LSB, D_HISTORY_LEN)) << FRAC_LEN);
	return sum >> FRAC_LEN;
endfunction

task automatic add_wr(int c, int id, logic [FEATURE_LEN-1:0] f);
	wr_id[c][n_wr[c]]   = ID_LEN'(id);
	wr_feat[c][n_wr[c]] = f;
	n_wr[c]++;
endtask

// expected result from the table contents the case leaves behind
task automatic predict(int c);
	bit                     live [N_OBJ];
	logic [FEATURE_LEN-1:0] feat [N_OBJ];
	int                     n_valid;
	int                     only_idx;
	longint                 s;
	n_valid  = 0;
	only_idx = 0;
	for (int i = 0; i < N_OBJ; i++)
		live[i] = 1'b0;
	for (int k = 0; k < n_wr[c]; k++) begin
		live[wr_id[c][k]] = !do_clear[c];
		feat[wr_id[c][k]] = wr_feat[c][k];
	end
	exp_found[c] = 1'b0;
	exp_id[c]    = '0;
	exp_score[c] = '0;
	for (int i = 0; i < N_OBJ; i++) begin
		if (live[i]) begin
			s = ref_score(c, feat[i]);
			if (!exp_found[c] || (s < exp_score[c])) begin   // strict, lower index keeps a tie
				exp_found[c] = 1'b1;
				exp_id[c]    = ID_LEN'(i);
				exp_score[c] = SCORE_LEN'(s);
			end
			n_valid++;
			only_idx = i;
		end
	end
	// busy, skipped slots, start, metric, result, then empty slots after it
	exp_lat[c] = (n_valid == 1)
	             ? 1 + only_idx + 1 + METRIC_CYCLES + 1 + (N_OBJ - 1 - only_idx) : -1;
endtask

task automatic build_cases();
	logic [FEATURE_LEN-1:0] f;
	for (int c = 0; c < N_CASES; c++) begin
		n_wr[c]     = 0;
		do_clear[c] = 1'b0;
		retrack[c]  = (c == 7) || (c == 10);
		det[c]      = make_entry(40, 40, 20, 16, 0, rnd_color(), rnd_color());
		for (int k = 0; k < 6; k++)
			wgt[c][k] = WEIGHT_LEN'($random(seed));
		if ((c == 3) || (c == 9) || (c == 10)) begin   // geometry decides
			wgt[c][3] = '0;
			wgt[c][4] = '0;
		end
		case (c)
			0: add_wr(c, 0, with_hist(det[c], 2));   // same box, iou of one
			1: add_wr(c, 2, with_hist(det[c], 5));
			2, 7: begin
				for (int k = 0; k < MAX_WR; k++)
					add_wr(c, k, make_entry(40 + 3 * k, 38 + 2 * k, 20, 16 + k, k,
					                        rnd_color(), rnd_color()));
			end
			3: begin   // 1 and 3 equal
				wgt[c][0] = 4'd8;
				wgt[c][5] = 4'd2;
				f = make_entry(42, 41, 20, 16, 0, rnd_color(), rnd_color());
				add_wr(c, 0, make_entry(50, 30, 20, 16, 1, rnd_color(), rnd_color()));
				add_wr(c, 3, f);
				add_wr(c, 2, make_entry(10, 10, 8, 8, 3, rnd_color(), rnd_color()));
				add_wr(c, 1, f);
			end
			4: add_wr(c, 1, make_entry(150, 150, 20, 16, 1, rnd_color(), rnd_color()));
			5: ;   // nothing written
			6: begin
				add_wr(c, 0, det[c]);
				add_wr(c, 3, make_entry(44, 40, 20, 16, 1, rnd_color(), rnd_color()));
				do_clear[c] = 1'b1;
			end
			8: add_wr(c, 3, make_entry(45, 44, 18, 14, 4, rnd_color(), rnd_color()));
			9: begin
				add_wr(c, 1, make_entry(100, 10, 20, 16, 0, rnd_color(), rnd_color()));
				add_wr(c, 2, make_entry(35, 45, 22, 15, 2, rnd_color(), rnd_color()));
			end
			10: begin
				add_wr(c, 0, make_entry(30, 30, 20, 16, 3, rnd_color(), rnd_color()));
				add_wr(c, 2, make_entry(41, 40, 20, 16, 2, rnd_color(), rnd_color()));
				add_wr(c, 3, make_entry(40, 42, 19, 16, 0, rnd_color(), rnd_color()));
			end
			default: begin   // equal boxes, history alone, 1 and 3 tie
				for (int k = 0; k < MAX_WR; k++)
					add_wr(c, k, with_hist(det[c], (k == 0) ? 3 : (k == 2) ? 4 : 1));
			end
		endcase
		predict(c);
	end
endtask

`endif

// ==== sim/oflow_tracker_tb.sv ====
`default_nettype none

module oflow_tracker_tb
	import oflow_feature_pkg::*;
	import oflow_score_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	`include "oflow_tracker_model.svh"

	localparam int CASE_CYCLES    = 80;   // table load plus a full four entry search
	localparam int TIMEOUT_CYCLES = 2 * N_CASES * CASE_CYCLES + 80;

	logic                    clk;
	logic                    reset_N;
	logic                    wr;
	logic [ID_LEN-1:0]       wr_addr;
	logic [FEATURE_LEN-1:0]  wr_features;
	logic                    clear;
	logic                    track;
	logic [POSITION_LEN-1:0] cur_position;
	logic [WIDTH_LEN-1:0]    cur_width;
	logic [HEIGHT_LEN-1:0]   cur_height;
	logic [COLOR_LEN-1:0]    cur_color1;
	logic [COLOR_LEN-1:0]    cur_color2;
	logic [WEIGHT_LEN-1:0]   iou_weight;
	logic [WEIGHT_LEN-1:0]   w_weight;
	logic [WEIGHT_LEN-1:0]   h_weight;
	logic [WEIGHT_LEN-1:0]   color1_weight;
	logic [WEIGHT_LEN-1:0]   color2_weight;
	logic [WEIGHT_LEN-1:0]   dhistory_weight;
	logic                    busy;
	logic                    done;
	logic                    found;
	logic [ID_LEN-1:0]       best_id;
	logic [SCORE_LEN-1:0]    best_score;
	int                      cycle_cnt = 0;

	oflow_tracker_top DUT (
		.clk(clk), .reset_N(reset_N),
		.wr(wr), .wr_addr(wr_addr), .wr_features(wr_features), .clear(clear),
		.track(track), .cur_position(cur_position), .cur_width(cur_width),
		.cur_height(cur_height), .cur_color1(cur_color1), .cur_color2(cur_color2),
		.iou_weight(iou_weight), .w_weight(w_weight), .h_weight(h_weight),
		.color1_weight(color1_weight), .color2_weight(color2_weight),
		.dhistory_weight(dhistory_weight),
		.busy(busy), .done(done), .found(found), .best_id(best_id), .best_score(best_score)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	// --------------------------------------------------
	// failure handling
	// --------------------------------------------------
	task automatic fail_stop(string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp)
			fail_stop($sformatf("MISMATCH time %0t ns %s got %0d expected %0d",
			                    $time, name, got, exp));
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			fail_stop($sformatf("timeout, tests still running after %0d cycles", cycle_cnt));
	end

	// --------------------------------------------------
	// stimulus, all edges on negedge
	// --------------------------------------------------
	task automatic load_table(int c);
		clear = 1'b1;   // start from an empty table
		@(negedge clk);
		clear = 1'b0;
		for (int k = 0; k < n_wr[c]; k++) begin
			wr          = 1'b1;
			wr_addr     = wr_id[c][k];
			wr_features = wr_feat[c][k];
			@(negedge clk);
		end
		wr    = 1'b0;
		clear = do_clear[c];
		@(negedge clk);
		clear = 1'b0;
	endtask

	task automatic run_case(int c);
		int lat;
		cur_position    = det[c][POSITION_LSB +: POSITION_LEN];
		cur_width       = det[c][WIDTH_LSB +: WIDTH_LEN];
		cur_height      = det[c][HEIGHT_LSB +: HEIGHT_LEN];
		cur_color1      = det[c][COLOR1_LSB +: COLOR_LEN];
		cur_color2      = det[c][COLOR2_LSB +: COLOR_LEN];
		iou_weight      = wgt[c][0];
		w_weight        = wgt[c][1];
		h_weight        = wgt[c][2];
		color1_weight   = wgt[c][3];
		color2_weight   = wgt[c][4];
		dhistory_weight = wgt[c][5];
		load_table(c);
		track = 1'b1;
		@(negedge clk);
		track = 1'b0;
		lat   = 1;
		check("busy", busy, 1);   // up one cycle after track
		while (!done) begin
			track = retrack[c] && (lat == 6);   // ignored, search already running
			@(negedge clk);
			lat++;
		end
		check("busy", busy, 0);   // falls with done
		check("found", found, exp_found[c]);
		if (exp_found[c]) begin
			check("best_id", best_id, exp_id[c]);
			check("best_score", best_score, exp_score[c]);
		end
		if (exp_lat[c] >= 0)
			check("done_latency", lat, exp_lat[c]);
		@(negedge clk);
		check("done", done, 0);   // single cycle pulse
		check("busy", busy, 0);   // no second search queued
	endtask

	initial begin
		reset_N         = 1'b0;
		wr              = 1'b0;
		wr_addr         = '0;
		wr_features     = '0;
		clear           = 1'b0;
		track           = 1'b0;
		cur_position    = '0;
		cur_width       = '0;
		cur_height      = '0;
		cur_color1      = '0;
		cur_color2      = '0;
		iou_weight      = '0;
		w_weight        = '0;
		h_weight        = '0;
		color1_weight   = '0;
		color2_weight   = '0;
		dhistory_weight = '0;
		build_cases();
		repeat (4) @(negedge clk);   // reset over 4 rising edges
		reset_N = 1'b1;
		check("busy", busy, 0);
		check("done", done, 0);
		check("found", found, 0);
		check("best_id", best_id, 0);
		check("best_score", best_score, 0);
		for (int c = 0; c < N_CASES; c++)
			run_case(c);
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
hw/oflow_feature_pkg.sv
hw/oflow_score_pkg.sv
hw/oflow_prev_table.sv
hw/oflow_calc_iou.sv
hw/oflow_similarity_metric.sv
hw/oflow_match_select.sv
hw/oflow_tracker_top.sv
sim/oflow_tracker_tb.sv

// ==== Bender.yml ====
package:
  name: oflow_tracker

sources:
  - hw/oflow_feature_pkg.sv
  - hw/oflow_score_pkg.sv
  - hw/oflow_prev_table.sv
  - hw/oflow_calc_iou.sv
  - hw/oflow_similarity_metric.sv
  - hw/oflow_match_select.sv
  - hw/oflow_tracker_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/oflow_tracker_tb.sv
